// File: xpu_pkg.sv
// xpu register map, widths, timing constants and the shared request and config structs
package xpu_pkg;

    // widths
    localparam int REG_DATA_W  = 32;
    localparam int REG_ADDR_W  = 6;  // 64 register words
    localparam int TSF_W       = 64;
    localparam int NUM_SLICES  = 3;
    localparam int SLICE_CNT_W = 25;
    localparam int SLICE_IDX_W = 2;

    // timing
    localparam int CLKS_PER_US = 200; // 200 MHz core clock
    localparam int PRESC_W     = $clog2(CLKS_PER_US);

    // field positions inside register words
    localparam int SLICE_SEL_LSB = SLICE_CNT_W;   // select sits just above the count
    localparam int TSF_LOAD_BIT  = REG_DATA_W - 1; // msb of the high load word
    localparam int OVR_STRIDE    = 8;              // override bits per slice
    localparam int OVR_EN_OFS    = 4;

    localparam logic [REG_DATA_W-1:0] XPU_VERSION = 32'h7c0e_0103;

    // register indices
    localparam logic [REG_ADDR_W-1:0] REG_OVERRIDE     = 6'd1;
    localparam logic [REG_ADDR_W-1:0] REG_TSF_LO       = 6'd2;
    localparam logic [REG_ADDR_W-1:0] REG_TSF_HI       = 6'd3;
    localparam logic [REG_ADDR_W-1:0] REG_SLICE_TOTAL  = 6'd20;
    localparam logic [REG_ADDR_W-1:0] REG_SLICE_START  = 6'd21;
    localparam logic [REG_ADDR_W-1:0] REG_SLICE_END    = 6'd22;
    localparam logic [REG_ADDR_W-1:0] REG_SLICE_STATUS = 6'd50;
    localparam logic [REG_ADDR_W-1:0] REG_TSF_RT_LO    = 6'd58;
    localparam logic [REG_ADDR_W-1:0] REG_TSF_RT_HI    = 6'd59;
    localparam logic [REG_ADDR_W-1:0] REG_VERSION      = 6'd63;

    // register write request, taken in the cycle it is presented
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } reg_wr_t;

    // register read request, answered one cycle later
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
    } reg_rd_t;

    typedef struct packed {
        logic             load; // one-cycle strobe
        logic [TSF_W-1:0] val;
    } tsf_load_t;

    // one slice's configuration; stop is the inclusive window end
    typedef struct packed {
        logic [SLICE_CNT_W-1:0] total;
        logic [SLICE_CNT_W-1:0] start;
        logic [SLICE_CNT_W-1:0] stop;
        logic                   force_en;
        logic                   force_val;
        logic                   restart; // pulse on any reconfiguration
    } slice_cfg_t;

endpackage

// File: xpu_regs.sv
// register bank with write decode, slice configuration, tsf load strobe and read mux
module xpu_regs import xpu_pkg::*; (
    input  logic                  s00_axi_aclk,
    input  logic                  reset_i,
    input  reg_wr_t               reg_wr_i,
    input  reg_rd_t               reg_rd_i,
    input  logic [TSF_W-1:0]      tsf_val_i,
    input  logic [NUM_SLICES-1:0] allowed_i,
    output logic [REG_DATA_W-1:0] rd_data_o,
    output logic                  rd_valid_o,
    output tsf_load_t             tsf_load_o,
    output slice_cfg_t            slice_cfg_o [NUM_SLICES]
);

    // whole words as last written, for readback
    logic [REG_DATA_W-1:0] override_q;
    logic [REG_DATA_W-1:0] tsf_lo_q;
    logic [REG_DATA_W-1:0] tsf_hi_q;
    logic [REG_DATA_W-1:0] total_word_q; // slice 0 only
    logic [REG_DATA_W-1:0] start_word_q;
    logic [REG_DATA_W-1:0] end_word_q;

    // per-slice fields
    logic [SLICE_CNT_W-1:0] total_q [NUM_SLICES];
    logic [SLICE_CNT_W-1:0] start_q [NUM_SLICES];
    logic [SLICE_CNT_W-1:0] stop_q  [NUM_SLICES];
    logic [NUM_SLICES-1:0]  restart_q;

    logic             load_q;
    logic [TSF_W-1:0] load_val_q;

    logic                   wr_override;
    logic                   wr_tsf_lo;
    logic                   wr_tsf_hi;
    logic                   wr_total;
    logic                   wr_start;
    logic                   wr_end;
    logic                   wr_slice;
    logic [SLICE_IDX_W-1:0] wr_sel;
    logic [SLICE_CNT_W-1:0] wr_cnt;

    assign wr_override = reg_wr_i.en && (reg_wr_i.addr == REG_OVERRIDE);
    assign wr_tsf_lo   = reg_wr_i.en && (reg_wr_i.addr == REG_TSF_LO);
    assign wr_tsf_hi   = reg_wr_i.en && (reg_wr_i.addr == REG_TSF_HI);
    assign wr_total    = reg_wr_i.en && (reg_wr_i.addr == REG_SLICE_TOTAL);
    assign wr_start    = reg_wr_i.en && (reg_wr_i.addr == REG_SLICE_START);
    assign wr_end      = reg_wr_i.en && (reg_wr_i.addr == REG_SLICE_END);
    assign wr_slice    = wr_total || wr_start || wr_end;
    assign wr_sel      = reg_wr_i.data[SLICE_SEL_LSB +: SLICE_IDX_W];
    assign wr_cnt      = reg_wr_i.data[SLICE_CNT_W-1:0];

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            override_q   <= '0;
            tsf_lo_q     <= '0;
            tsf_hi_q     <= '0;
            total_word_q <= '0;
            start_word_q <= '0;
            end_word_q   <= '0;
            restart_q    <= '0;
            load_q       <= 1'b0;
            for (int k = 0; k < NUM_SLICES; k++) begin
                total_q[k] <= '0;
                start_q[k] <= '0;
                stop_q[k]  <= '0;
            end
        end else begin
            load_q <= wr_tsf_hi && reg_wr_i.data[TSF_LOAD_BIT];
            if (wr_override) override_q <= reg_wr_i.data;
            if (wr_tsf_lo)   tsf_lo_q   <= reg_wr_i.data;
            if (wr_tsf_hi)   tsf_hi_q   <= reg_wr_i.data;
            if (wr_sel == '0) begin // readback mirrors slice 0
                if (wr_total) total_word_q <= reg_wr_i.data;
                if (wr_start) start_word_q <= reg_wr_i.data;
                if (wr_end)   end_word_q   <= reg_wr_i.data;
            end
            // select 3 matches no slice and is dropped
            for (int k = 0; k < NUM_SLICES; k++) begin
                restart_q[k] <= wr_slice && (wr_sel == SLICE_IDX_W'(k));
                if (wr_sel == SLICE_IDX_W'(k)) begin
                    if (wr_total) total_q[k] <= wr_cnt;
                    if (wr_start) start_q[k] <= wr_cnt;
                    if (wr_end)   stop_q[k]  <= wr_cnt;
                end
            end
        end
    end

    // load value, bit 63 always clear
    always_ff @(posedge s00_axi_aclk) begin
        if (wr_tsf_hi) begin
            load_val_q <= {1'b0, reg_wr_i.data[TSF_W-REG_DATA_W-2:0], tsf_lo_q};
        end
    end

    assign tsf_load_o.load = load_q;
    assign tsf_load_o.val  = load_val_q;

    always_comb begin
        for (int k = 0; k < NUM_SLICES; k++) begin
            slice_cfg_o[k].total     = total_q[k];
            slice_cfg_o[k].start     = start_q[k];
            slice_cfg_o[k].stop      = stop_q[k];
            slice_cfg_o[k].force_en  = override_q[OVR_STRIDE*k + OVR_EN_OFS];
            slice_cfg_o[k].force_val = override_q[OVR_STRIDE*k];
            slice_cfg_o[k].restart   = restart_q[k];
        end
    end

    // registered read mux
    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= reg_rd_i.en;
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (reg_rd_i.en) begin
            case (reg_rd_i.addr)
                REG_OVERRIDE:     rd_data_o <= override_q;
                REG_TSF_LO:       rd_data_o <= tsf_lo_q;
                REG_TSF_HI:       rd_data_o <= tsf_hi_q;
                REG_SLICE_TOTAL:  rd_data_o <= total_word_q;
                REG_SLICE_START:  rd_data_o <= start_word_q;
                REG_SLICE_END:    rd_data_o <= end_word_q;
                REG_SLICE_STATUS: rd_data_o <= REG_DATA_W'(allowed_i);
                REG_TSF_RT_LO:    rd_data_o <= tsf_val_i[REG_DATA_W-1:0];
                REG_TSF_RT_HI:    rd_data_o <= tsf_val_i[TSF_W-1:REG_DATA_W];
                REG_VERSION:      rd_data_o <= XPU_VERSION;
                default:          rd_data_o <= '0; // unmapped
            endcase
        end
    end

endmodule

// File: tsf_timer.sv
// 1 MHz tick prescaler and loadable 64-bit tsf counter
module tsf_timer import xpu_pkg::*; (
    input  logic             s00_axi_aclk,
    input  logic             reset_i,
    input  tsf_load_t        tsf_load_i,
    output logic [TSF_W-1:0] tsf_val_o,
    output logic             tsf_pulse_o
);

    logic [PRESC_W-1:0] presc_q;
    logic               presc_wrap;

    assign presc_wrap = (presc_q == PRESC_W'(CLKS_PER_US - 1));

    // prescaler, restarted by a load
    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            presc_q     <= '0;
            tsf_pulse_o <= 1'b0;
        end else if (tsf_load_i.load) begin
            presc_q     <= '0;
            tsf_pulse_o <= 1'b0;
        end else begin
            tsf_pulse_o <= presc_wrap; // one cycle every CLKS_PER_US
            if (presc_wrap) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
        end
    end

    // microsecond counter, load takes priority over the tick
    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            tsf_val_o <= '0;
        end else if (tsf_load_i.load) begin
            tsf_val_o <= tsf_load_i.val;
        end else if (tsf_pulse_o) begin
            tsf_val_o <= tsf_val_o + 1'b1; // cycle after the tick
        end
    end

endmodule

// File: slice_unit.sv
// one time slice with tick counter, window compare and software override
module slice_unit import xpu_pkg::*; (
    input  logic       s00_axi_aclk,
    input  logic       reset_i,
    input  logic       tsf_pulse_i,
    input  slice_cfg_t cfg_i,
    output logic       allowed_o
);

    logic [SLICE_CNT_W-1:0] count_q;
    logic [SLICE_CNT_W-1:0] total_q;
    logic [SLICE_CNT_W-1:0] start_q;
    logic [SLICE_CNT_W-1:0] stop_q;
    logic                   force_en_q;
    logic                   force_val_q;
    logic                   in_window;

    // local copy of the configuration
    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            total_q     <= '0;
            start_q     <= '0;
            stop_q      <= '0;
            force_en_q  <= 1'b0;
            force_val_q <= 1'b0;
        end else begin
            total_q     <= cfg_i.total;
            start_q     <= cfg_i.start;
            stop_q      <= cfg_i.stop;
            force_en_q  <= cfg_i.force_en;
            force_val_q <= cfg_i.force_val;
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (cfg_i.restart) begin
            count_q <= '0;
        end else if (tsf_pulse_i) begin
            if (total_q == '0) begin
                count_q <= '0; // idle slice holds at 0
            end else if (count_q >= total_q - 1'b1) begin
                count_q <= '0; // end of period
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // inclusive window
    assign in_window = (count_q >= start_q) && (count_q <= stop_q);
    assign allowed_o = force_en_q ? force_val_q : in_window;

endmodule

// File: xpu_top.sv
// timing core top level with register bank, tsf timer and the slice units
module xpu_top import xpu_pkg::*; (
    input  logic                  s00_axi_aclk,
    input  logic                  reset_i,
    input  reg_wr_t               reg_wr_i,
    input  reg_rd_t               reg_rd_i,
    output logic [REG_DATA_W-1:0] rd_data_o,
    output logic                  rd_valid_o,
    output logic [TSF_W-1:0]      tsf_o,
    output logic                  tsf_pulse_1m_o,
    output logic [NUM_SLICES-1:0] high_tx_allowed_o
);

    tsf_load_t             tsf_load;
    logic [TSF_W-1:0]      tsf_val;
    logic                  tsf_pulse;
    slice_cfg_t            slice_cfg [NUM_SLICES];
    logic [NUM_SLICES-1:0] allowed;

    xpu_regs xpu_regs_i (
        .s00_axi_aclk (s00_axi_aclk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .tsf_val_i    (tsf_val),
        .allowed_i    (allowed),
        .rd_data_o    (rd_data_o),
        .rd_valid_o   (rd_valid_o),
        .tsf_load_o   (tsf_load),
        .slice_cfg_o  (slice_cfg)
    );

    // 200 MHz clock in, 1 MHz tick out
    tsf_timer tsf_timer_i (
        .s00_axi_aclk (s00_axi_aclk),
        .reset_i      (reset_i),
        .tsf_load_i   (tsf_load),
        .tsf_val_o    (tsf_val),
        .tsf_pulse_o  (tsf_pulse)
    );

    for (genvar k = 0; k < NUM_SLICES; k++) begin : g_slice
        slice_unit slice_unit_i (
            .s00_axi_aclk (s00_axi_aclk),
            .reset_i      (reset_i),
            .tsf_pulse_i  (tsf_pulse),
            .cfg_i        (slice_cfg[k]),
            .allowed_o    (allowed[k])
        );
    end

    assign tsf_o             = tsf_val;
    assign tsf_pulse_1m_o    = tsf_pulse;
    assign high_tx_allowed_o = allowed;

endmodule

// File: tb_xpu_assert.sv
// bound assertion checker with shadow models of tsf, slice counters and register readback
module xpu_assert import xpu_pkg::*; (
    input logic                  s00_axi_aclk,
    input logic                  reset_i,
    input reg_wr_t               reg_wr_i,
    input reg_rd_t               reg_rd_i,
    input logic [REG_DATA_W-1:0] rd_data_o,
    input logic                  rd_valid_o,
    input logic [TSF_W-1:0]      tsf_o,
    input logic                  tsf_pulse_1m_o,
    input logic [NUM_SLICES-1:0] high_tx_allowed_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // readback words as written
    logic [REG_DATA_W-1:0] lo_word;
    logic [REG_DATA_W-1:0] hi_word;
    logic [REG_DATA_W-1:0] ovr_word;
    logic [REG_DATA_W-1:0] tot_word0;
    logic [REG_DATA_W-1:0] start_word0;
    logic [REG_DATA_W-1:0] end_word0;

    logic                   ld_pend;
    logic [TSF_W-1:0]       ld_val;
    logic [TSF_W-1:0]       exp_tsf;
    int                     gap;        // cycles since the last tick, load or reset
    slice_cfg_t             cfg1 [NUM_SLICES]; // as held by the register bank
    slice_cfg_t             cfg2 [NUM_SLICES]; // as seen by the slice compare
    logic [SLICE_CNT_W-1:0] cnt  [NUM_SLICES];
    logic                   rd_pend;
    logic [REG_DATA_W-1:0]  rd_exp;

    logic [NUM_SLICES-1:0]  exp_win;
    logic [NUM_SLICES-1:0]  exp_force_en;
    logic [NUM_SLICES-1:0]  exp_force_val;
    logic [NUM_SLICES-1:0]  exp_allowed;
    logic                   exp_tick;
    logic                   wr_slice;
    logic [SLICE_IDX_W-1:0] wr_sel;
    logic [SLICE_CNT_W-1:0] wr_cnt;

    assign exp_tick = (gap == CLKS_PER_US);
    assign wr_slice = reg_wr_i.en && (reg_wr_i.addr == REG_SLICE_TOTAL
        || reg_wr_i.addr == REG_SLICE_START || reg_wr_i.addr == REG_SLICE_END);
    assign wr_sel   = reg_wr_i.data[SLICE_SEL_LSB +: SLICE_IDX_W];
    assign wr_cnt   = reg_wr_i.data[SLICE_CNT_W-1:0];

    always_comb begin
        for (int k = 0; k < NUM_SLICES; k++) begin
            exp_win[k]       = (cnt[k] >= cfg2[k].start) && (cnt[k] <= cfg2[k].stop);
            exp_force_en[k]  = cfg2[k].force_en;
            exp_force_val[k] = cfg2[k].force_val;
        end
        exp_allowed = (exp_force_en & exp_force_val) | (~exp_force_en & exp_win);
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            lo_word     <= '0;
            hi_word     <= '0;
            ovr_word    <= '0;
            tot_word0   <= '0;
            start_word0 <= '0;
            end_word0   <= '0;
            ld_pend     <= 1'b0;
            exp_tsf     <= '0;
            gap         <= 0;
            rd_pend     <= 1'b0;
            for (int k = 0; k < NUM_SLICES; k++) begin
                cfg1[k] <= '0;
                cfg2[k] <= '0;
                cnt[k]  <= '0;
            end
        end else begin
            ld_pend <= reg_wr_i.en && reg_wr_i.addr == REG_TSF_HI
                && reg_wr_i.data[REG_DATA_W-1];
            if (reg_wr_i.en && reg_wr_i.addr == REG_TSF_HI) begin
                ld_val <= {1'b0, reg_wr_i.data[REG_DATA_W-2:0], lo_word};
            end
            if (ld_pend) begin // load also restarts the tick period
                exp_tsf <= ld_val;
                gap     <= 0;
            end else begin
                if (exp_tick) exp_tsf <= exp_tsf + TSF_W'(1);
                gap <= exp_tick ? 1 : gap + 1;
            end
            if (reg_wr_i.en) begin
                case (reg_wr_i.addr)
                    REG_OVERRIDE: ovr_word <= reg_wr_i.data;
                    REG_TSF_LO:   lo_word  <= reg_wr_i.data;
                    REG_TSF_HI:   hi_word  <= reg_wr_i.data;
                    default: ;
                endcase
                if (wr_sel == '0) begin
                    if (reg_wr_i.addr == REG_SLICE_TOTAL) tot_word0   <= reg_wr_i.data;
                    if (reg_wr_i.addr == REG_SLICE_START) start_word0 <= reg_wr_i.data;
                    if (reg_wr_i.addr == REG_SLICE_END)   end_word0   <= reg_wr_i.data;
                end
            end
            for (int k = 0; k < NUM_SLICES; k++) begin
                cfg1[k].restart <= wr_slice && (wr_sel == SLICE_IDX_W'(k));
                if (wr_slice && wr_sel == SLICE_IDX_W'(k)) begin
                    if (reg_wr_i.addr == REG_SLICE_TOTAL) cfg1[k].total <= wr_cnt;
                    if (reg_wr_i.addr == REG_SLICE_START) cfg1[k].start <= wr_cnt;
                    if (reg_wr_i.addr == REG_SLICE_END)   cfg1[k].stop  <= wr_cnt;
                end
                if (reg_wr_i.en && reg_wr_i.addr == REG_OVERRIDE) begin
                    cfg1[k].force_en  <= reg_wr_i.data[OVR_STRIDE*k + OVR_EN_OFS];
                    cfg1[k].force_val <= reg_wr_i.data[OVR_STRIDE*k];
                end
                cfg2[k] <= cfg1[k];
                if (cfg1[k].restart) begin
                    cnt[k] <= '0;
                end else if (exp_tick) begin
                    if (cfg2[k].total == '0 || cnt[k] == cfg2[k].total - SLICE_CNT_W'(1)) begin
                        cnt[k] <= '0; // idle slice or end of period
                    end else begin
                        cnt[k] <= cnt[k] + SLICE_CNT_W'(1);
                    end
                end
            end
            rd_pend <= reg_rd_i.en;
            if (reg_rd_i.en) begin
                case (reg_rd_i.addr)
                    REG_OVERRIDE:     rd_exp <= ovr_word;
                    REG_TSF_LO:       rd_exp <= lo_word;
                    REG_TSF_HI:       rd_exp <= hi_word;
                    REG_SLICE_TOTAL:  rd_exp <= tot_word0;
                    REG_SLICE_START:  rd_exp <= start_word0;
                    REG_SLICE_END:    rd_exp <= end_word0;
                    REG_SLICE_STATUS: rd_exp <= REG_DATA_W'(exp_allowed);
                    REG_TSF_RT_LO:    rd_exp <= exp_tsf[REG_DATA_W-1:0];
                    REG_TSF_RT_HI:    rd_exp <= exp_tsf[TSF_W-1:REG_DATA_W];
                    REG_VERSION:      rd_exp <= XPU_VERSION;
                    default:          rd_exp <= '0;
                endcase
            end
        end
    end

    a_reset: assert property (@(posedge s00_axi_aclk) $fell(reset_i) |->
        (tsf_o == '0 && !tsf_pulse_1m_o && !rd_valid_o && &high_tx_allowed_o))
        else begin
            fail_cnt++;
            $error({"CHECK FAILED reset state: expected tsf 0 pulse 0 valid 0 allowed 7, ",
                "actual tsf %0h pulse %0b valid %0b allowed %0h"},
                tsf_o, tsf_pulse_1m_o, rd_valid_o, high_tx_allowed_o);
        end

    a_tick: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
        tsf_pulse_1m_o == exp_tick)
        else begin
            fail_cnt++;
            $error("CHECK FAILED tick: expected pulse %0b actual %0b",
                exp_tick, tsf_pulse_1m_o);
        end

    a_tsf: assert property (@(posedge s00_axi_aclk) disable iff (reset_i) tsf_o == exp_tsf)
        else begin
            fail_cnt++;
            $error("CHECK FAILED tsf value: expected %0h actual %0h", exp_tsf, tsf_o);
        end

    a_window: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
        (high_tx_allowed_o & ~exp_force_en) == (exp_win & ~exp_force_en))
        else begin
            fail_cnt++;
            $error("CHECK FAILED slice window: expected %0b actual %0b (forced %0b)",
                exp_win, high_tx_allowed_o, exp_force_en);
        end

    a_override: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
        (high_tx_allowed_o & exp_force_en) == (exp_force_val & exp_force_en))
        else begin
            fail_cnt++;
            $error("CHECK FAILED override: expected %0b actual %0b (forced %0b)",
                exp_force_val, high_tx_allowed_o, exp_force_en);
        end

    a_rd_valid: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
        rd_valid_o == rd_pend)
        else begin
            fail_cnt++;
            $error("CHECK FAILED read valid: expected %0b actual %0b", rd_pend, rd_valid_o);
        end

    a_rd_data: assert property (@(posedge s00_axi_aclk) disable iff (reset_i)
        rd_pend |-> rd_data_o == rd_exp)
        else begin
            fail_cnt++;
            $error("CHECK FAILED readback: expected %0h actual %0h", rd_exp, rd_data_o);
        end

endmodule

// File: tb_xpu.sv
// testbench for xpu_top with clock, reset, random stimulus, watchdog and final verdict
module tb_xpu import xpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 10;
    localparam int MAX_TOTAL   = 20;
    localparam int NUM_ROUNDS  = 6;
    localparam int ROUND_TICKS = MAX_TOTAL + 6;  // each round covers more than one period
    localparam int TEST_TICKS  = MAX_TOTAL + 12; // upper bound per test incl. writes
    localparam int NUM_TESTS   = NUM_ROUNDS + 2;
    localparam int TIMEOUT_NS  = 2 * NUM_TESTS * TEST_TICKS * CLKS_PER_US * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    reg_wr_t               reg_wr;
    reg_rd_t               reg_rd;
    logic [REG_DATA_W-1:0] rd_data;
    logic                  rd_valid;
    logic [TSF_W-1:0]      tsf;
    logic                  tsf_pulse;
    logic [NUM_SLICES-1:0] allowed;
    integer                seed = 32'h3e66;

    xpu_top dut_i (
        .s00_axi_aclk      (clk),
        .reset_i           (reset),
        .reg_wr_i          (reg_wr),
        .reg_rd_i          (reg_rd),
        .rd_data_o         (rd_data),
        .rd_valid_o        (rd_valid),
        .tsf_o             (tsf),
        .tsf_pulse_1m_o    (tsf_pulse),
        .high_tx_allowed_o (allowed)
    );

    bind xpu_top xpu_assert xpu_assert_i (
        .s00_axi_aclk      (s00_axi_aclk),
        .reset_i           (reset_i),
        .reg_wr_i          (reg_wr_i),
        .reg_rd_i          (reg_rd_i),
        .rd_data_o         (rd_data_o),
        .rd_valid_o        (rd_valid_o),
        .tsf_o             (tsf_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m_o),
        .high_tx_allowed_o (high_tx_allowed_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // all tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
        reg_wr.en   = 1'b1;
        reg_wr.addr = addr;
        reg_wr.data = data;
        @(posedge clk);
        #1;
        reg_wr.en = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr);
        reg_rd.en   = 1'b1;
        reg_rd.addr = addr;
        @(posedge clk);
        #1;
        reg_rd.en = 1'b0;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n) @(posedge tsf_pulse);
        #1;
    endtask

    // random junk above the select field checks whole-word readback
    function automatic logic [REG_DATA_W-1:0] slice_word(input int sel, input int unsigned cnt);
        logic [REG_DATA_W-1:0] w;
        w = $random(seed);
        w[SLICE_SEL_LSB +: SLICE_IDX_W] = SLICE_IDX_W'(sel);
        w[SLICE_CNT_W-1:0] = SLICE_CNT_W'(cnt);
        return w;
    endfunction

    task automatic config_slice(input int k);
        int unsigned total;
        int unsigned start;
        int unsigned stop;
        total = 2 + $unsigned($random(seed)) % (MAX_TOTAL - 1);
        start = $unsigned($random(seed)) % total;
        stop  = start + $unsigned($random(seed)) % (total - start);
        write_reg(REG_SLICE_TOTAL, slice_word(k, total));
        write_reg(REG_SLICE_START, slice_word(k, start));
        write_reg(REG_SLICE_END, slice_word(k, stop));
    endtask

    // stop at the first assertion failure
    initial begin
        wait (dut_i.xpu_assert_i.fail_cnt != 0);
        $display("*** TEST FAILED ***");
        $fatal(1, "an assertion check failed");
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset  = 1'b1;
        reg_wr = '0;
        reg_rd = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        read_reg(REG_VERSION);
        read_reg(REG_SLICE_STATUS);
        read_reg(6'd40); // unmapped
        wait_ticks(2);

        // tsf load, then a high word without the load bit
        write_reg(REG_TSF_LO, $random(seed));
        write_reg(REG_TSF_HI, {1'b1, 31'($random(seed))});
        read_reg(REG_TSF_RT_LO);
        wait_ticks(3);
        read_reg(REG_TSF_RT_LO);
        read_reg(REG_TSF_RT_HI);
        write_reg(REG_TSF_LO, $random(seed));
        write_reg(REG_TSF_HI, {1'b0, 31'($random(seed))});
        wait_ticks(2);
        read_reg(REG_TSF_LO);
        read_reg(REG_TSF_HI);
        read_reg(REG_TSF_RT_HI);

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            for (int k = 0; k < NUM_SLICES; k++) begin
                config_slice(k);
            end
            write_reg(REG_SLICE_TOTAL, slice_word(3, 7)); // select 3 is dropped
            read_reg(REG_SLICE_TOTAL);
            read_reg(REG_SLICE_START);
            read_reg(REG_SLICE_END);
            repeat (ROUND_TICKS) begin
                wait_ticks(1);
                read_reg(REG_SLICE_STATUS);
            end
            write_reg(REG_OVERRIDE, $random(seed));
            read_reg(REG_OVERRIDE);
            repeat (4) begin
                wait_ticks(1);
                read_reg(REG_SLICE_STATUS);
            end
            write_reg(REG_OVERRIDE, '0);
            read_reg(REG_SLICE_STATUS);
        end

        read_reg(REG_TSF_RT_LO);
        read_reg(REG_VERSION);
        repeat (2) @(posedge clk);
        #1;
        if (dut_i.xpu_assert_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures were counted");
        end
    end

endmodule

// File: build.f
xpu_pkg.sv
xpu_regs.sv
tsf_timer.sv
slice_unit.sv
xpu_top.sv
tb_xpu_assert.sv
tb_xpu.sv

// File: Makefile
# Verilator build and run for the xpu timing core testbench

VERILATOR ?= verilator
TOP       ?= tb_xpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
